//--- dv/mpu_ext_props.sv
/*
 * Credit and buffer properties
 * Output credit limit, ring buffer push and pop rules, memory strobes
 */
module mpu_ext_props
	import mpu_ext_pkg::*;
(
	input logic      clock,
	input logic      reset,
	input ext_word_t ext_out,
	input logic      ext_out_credit,
	input logic      push,
	input logic      pop,
	input logic      full,
	input logic      empty,
	input mem_req_t  mem_req,
	input logic      mem_grant
);

	int outstanding;	// Words sent minus credits returned

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(ext_out.valid) - int'(ext_out_credit);
		end
	end

	out_credit_limit: assert property (@(posedge clock) disable iff (reset)
		outstanding <= EXT_OUT_CREDITS)
		else $error("output words exceed the returned credits");

	push_when_full: assert property (@(posedge clock) disable iff (reset)
		!(push && full && !pop))
		else $error("ring buffer pushed while full");

	pop_when_empty: assert property (@(posedge clock) disable iff (reset)
		!(pop && empty))
		else $error("ring buffer popped while empty");

	strobe_needs_grant: assert property (@(posedge clock) disable iff (reset)
		(mem_req.wr || mem_req.rd) |-> mem_grant)
		else $error("memory strobe without grant");

endmodule

bind mpu_ext_top mpu_ext_props u_props_top (
	.clock          (clock),
	.reset          (reset),
	.ext_out        (ext_out),
	.ext_out_credit (ext_out_credit),
	.push           (push),
	.pop            (pop),
	.full           (full),
	.empty          (empty),
	.mem_req        (mem_req),
	.mem_grant      (mem_grant)
);

bind data_service mpu_ext_props u_props_service (
	.clock          (clock),
	.reset          (reset),
	.ext_out        (ext_out),
	.ext_out_credit (ext_out_credit),
	.push           (push),
	.pop            (pop),
	.full           (full),
	.empty          (empty),
	.mem_req        (mem_req),
	.mem_grant      (mem_grant)
);

//--- dv/mpu_ext_tb.sv
/*
 * Testbench for the MPU external data service
 * Runs a table of store and load commands with LFSR data against a
 * memory model, with credit flow on both external ports
 */
module mpu_ext_tb
	import mpu_ext_pkg::*;
();

	localparam int          NUM_CMDS   = 12;
	localparam int          WAIT_LIMIT = 2000;	// Cycles per wait
	localparam logic [15:0] LFSR_SEED  = 16'd16928;

	typedef struct packed {
		logic       is_load;
		addr_t      stride;
		len_t       length;
		addr_t      base;
		logic [7:0] gap;	// Cycles before a received word's credit goes back
	} cmd_entry_t;

	logic      clock;
	logic      reset;
	ext_word_t ext_in;
	logic      ext_out_credit;
	logic      ext_in_credit;
	ext_word_t ext_out;
	logic      busy;

	cmd_entry_t  cmd_table [NUM_CMDS];
	data_t       model [MEM_DEPTH];
	data_t       word_q [$];
	data_t       expect_q [$];
	int          return_q [$];	// Cycle at which each output credit goes back
	logic [15:0] lfsr;
	int          cycle;
	int          in_sent;
	int          in_returned;
	int          in_pulses;
	int          out_seen;
	int          out_returned;
	int          gap_now;
	int          mismatch_count;
	int          error_count;
	logic        aborted;

	mpu_ext_top u_dut (
		.clock          (clock),
		.reset          (reset),
		.ext_in         (ext_in),
		.ext_out_credit (ext_out_credit),
		.ext_in_credit  (ext_in_credit),
		.ext_out        (ext_out),
		.busy           (busy)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	task automatic check_value(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			$display("mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			mismatch_count++;
		end
	endtask

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic data_t random_word();
		data_t word;
		logic  feedback;
		word = '0;
		for (int b = 0; b < WIDTH_DATA; b++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr     = {lfsr[14:0], feedback};
			word     = {word[WIDTH_DATA-2:0], feedback};
		end
		return word;
	endfunction

	function automatic int credits_free();
		return BUFF_DEPTH - in_sent + in_returned;
	endfunction

	////////////////////////////// Sender
	task automatic send_words();
		int stall;
		stall = 0;
		while (word_q.size() > 0 && !aborted) begin
			@(posedge clock);
			#1;
			if (credits_free() > 0) begin
				ext_in = '{valid: 1'b1, data: word_q.pop_front()};
				in_sent++;
				stall = 0;
			end else begin
				ext_in.valid = 1'b0;
				stall++;
				if (stall >= WAIT_LIMIT) begin
					$display("error at time %0t: no input credit came back in %0d cycles",
						$time, WAIT_LIMIT);
					error_count++;
					aborted = 1'b1;
				end
			end
		end
		@(posedge clock);
		#1;
		ext_in = '0;
	endtask

	task automatic wait_idle();
		int stall;
		stall = 0;
		do begin
			@(negedge clock);
			stall++;
		end while (busy && stall < WAIT_LIMIT);
		if (busy) begin
			$display("error at time %0t: busy still high after %0d cycles", $time, WAIT_LIMIT);
			error_count++;
			aborted = 1'b1;
		end
	endtask

	////////////////////////////// Receiver side
	// Returns one output credit per cycle once its gap has passed
	initial begin
		cycle          = 0;
		ext_out_credit = 1'b0;
		out_returned   = 0;
		forever begin
			@(posedge clock);
			cycle++;
			#1;
			if (return_q.size() > 0 && return_q[0] <= cycle) begin
				void'(return_q.pop_front());
				ext_out_credit = 1'b1;
				out_returned++;
			end else begin
				ext_out_credit = 1'b0;
			end
		end
	end

	// Outputs sampled mid-cycle
	initial begin
		in_returned = 0;
		in_pulses   = 0;
		out_seen    = 0;
		forever begin
			@(negedge clock);
			if (!reset) begin
				if (ext_in_credit) begin
					in_returned++;
					in_pulses++;
				end
				if (ext_out.valid) begin
					if (expect_q.size() == 0) begin
						$display("error at time %0t: output word %h arrived with none expected",
							$time, ext_out.data);
						error_count++;
					end else begin
						check_value("ext_out.data", ext_out.data, expect_q.pop_front());
					end
					out_seen++;
					return_q.push_back(cycle + gap_now);
					if (out_seen - out_returned > EXT_OUT_CREDITS) begin
						$display("error at time %0t: more output words than credits allow", $time);
						error_count++;
					end
				end
			end
		end
	end

	////////////////////////////// Main sequence
	initial begin
		cmd_entry_t entry;
		int         n_words;
		int         addr;
		int         pulses_at_start;
		data_t      word;
		reset          = 1'b1;
		ext_in         = '0;
		in_sent        = 0;
		gap_now        = 0;
		mismatch_count = 0;
		error_count    = 0;
		aborted        = 1'b0;
		lfsr           = LFSR_SEED;
		// is_load, stride, length, base, gap
		cmd_table = '{
			'{1'b0, 8'd1, 8'd12, 8'd16, 8'd0},
			'{1'b1, 8'd1, 8'd12, 8'd16, 8'd0},
			'{1'b0, 8'd3, 8'd20, 8'd40, 8'd2},
			'{1'b0, 8'd2, 8'd10, 8'd40, 8'd0},	// Overwrites part of the stride 3 set
			'{1'b1, 8'd3, 8'd20, 8'd40, 8'd5},
			'{1'b1, 8'd2, 8'd10, 8'd40, 8'd9},
			'{1'b0, 8'd5, 8'd24, 8'd230, 8'd0},	// Wraps past MEM_DEPTH
			'{1'b1, 8'd5, 8'd24, 8'd230, 8'd3},
			'{1'b1, 8'd3, 8'd20, 8'd40, 8'd1},
			'{1'b1, 8'd1, 8'd12, 8'd16, 8'd0},
			'{1'b0, 8'd7, 8'd40, 8'd200, 8'd0},	// Longer than the buffer
			'{1'b1, 8'd7, 8'd40, 8'd200, 8'd4}
		};
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;

		// Quiet until the first header word
		repeat (4) begin
			@(negedge clock);
			check_value("ext_out.valid", data_t'(ext_out.valid), '0);
			check_value("ext_in_credit", data_t'(ext_in_credit), '0);
			check_value("busy", data_t'(busy), '0);
		end

		for (int i = 0; i < NUM_CMDS && !aborted; i++) begin
			entry   = cmd_table[i];
			gap_now = int'(entry.gap);
			n_words = (entry.length == '0) ? MEM_DEPTH : int'(entry.length);
			word_q.push_back(data_t'(entry.is_load ? OP_LOAD : OP_STORE));
			word_q.push_back(data_t'(entry.stride));
			word_q.push_back(data_t'(entry.length));
			word_q.push_back(data_t'(entry.base));
			for (int k = 0; k < n_words; k++) begin
				addr = (int'(entry.base) + k * int'(entry.stride)) % MEM_DEPTH;
				if (entry.is_load) begin
					expect_q.push_back(model[addr]);
				end else begin
					word        = random_word();
					model[addr] = word;
					word_q.push_back(word);
				end
			end
			pulses_at_start = in_pulses;
			send_words();
			if (!aborted) begin
				wait_idle();
			end
			if (!aborted) begin
				check_value("ext_in_credit pulses", data_t'(in_pulses - pulses_at_start),
					data_t'(4 + (entry.is_load ? 0 : n_words)));
				check_value("input credits", data_t'(credits_free()), data_t'(BUFF_DEPTH));
				if (expect_q.size() != 0) begin
					$display("error at time %0t: command %0d ended with %0d words not received",
						$time, i, expect_q.size());
					error_count++;
					expect_q.delete();
				end
			end
		end

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- logic/data_memory.sv
/*
 * Data memory
 * Single-port word store with request, grant and release handshake
 * and a strided address generator
 */
module data_memory
	import mpu_ext_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  ext_cmd_t cmd,
	input  mem_req_t mem_req,
	output logic     mem_grant,
	output data_t    mem_rdata
);

	data_t storage [MEM_DEPTH];
	addr_t addr_q;
	logic  grant_q;
	data_t rdata_q;
	logic  access;

	assign mem_grant = grant_q;
	assign mem_rdata = rdata_q;
	assign access    = grant_q & (mem_req.wr | mem_req.rd);

	////////////////////////////// Handshake
	// Single client, granted the cycle after its request
	always_ff @(posedge clock) begin
		if (reset) begin
			grant_q <= 1'b0;
		end else if (mem_req.rls) begin
			grant_q <= 1'b0;
		end else if (mem_req.req) begin
			grant_q <= 1'b1;
		end
	end

	////////////////////////////// Address generator
	// 8-bit sum wraps modulo MEM_DEPTH
	always_ff @(posedge clock) begin
		if (reset) begin
			addr_q <= '0;
		end else if (mem_req.rls || (mem_req.req && !grant_q)) begin
			addr_q <= cmd.base;	// Start or restart at the command base
		end else if (access) begin
			addr_q <= addr_q + cmd.stride;
		end
	end

	always_ff @(posedge clock) begin
		if (grant_q && mem_req.wr) begin
			storage[addr_q] <= mem_req.wdata;
		end
	end

	// Read data one cycle after the strobe
	always_ff @(posedge clock) begin
		if (grant_q && mem_req.rd) begin
			rdata_q <= storage[addr_q];
		end
	end

endmodule

//--- logic/data_service.sv
/*
 * Data service engines
 * Store moves external words through the ring buffer into data memory,
 * load reads strided words back through the buffer to the output port
 */
module data_service
	import mpu_ext_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  ext_cmd_t            cmd,
	input  logic                cmd_valid,
	input  ext_word_t           store_in,
	input  logic                hdr_credit,
	input  logic                ext_out_credit,
	input  logic                mem_grant,
	input  data_t               mem_rdata,
	input  data_t               pop_data,
	input  logic                full,
	input  logic                empty,
	input  logic [WIDTH_BUFF:0] count,
	output logic                cmd_done,
	output ext_word_t           ext_out,
	output logic                ext_in_credit,
	output mem_req_t            mem_req,
	output logic                push,
	output data_t               push_data,
	output logic                pop
);

	serv_state_e             state;
	len_t                    last_idx;
	len_t                    mem_cnt;	// Writes for store, reads for load
	len_t                    out_cnt;	// Words sent on a load
	logic                    mem_last;
	logic                    out_last;
	logic                    rd_q;	// Read in flight
	logic                    in_credit_q;
	logic [WIDTH_CREDIT-1:0] out_credits;
	logic [WIDTH_BUFF:0]     occupied;
	logic                    rd_room;
	logic                    wr_strobe;
	logic                    rd_strobe;
	logic                    out_pop;
	logic                    out_valid_q;
	data_t                   out_data_q;

	// Length zero wraps to index 255, i.e. 256 words
	assign last_idx = cmd.length - 1'b1;
	assign mem_last = mem_cnt == last_idx;
	assign out_last = out_cnt == last_idx;

	// Buffer space has to cover the word still coming back from memory
	assign occupied = count + {{WIDTH_BUFF{1'b0}}, rd_q};
	assign rd_room  = ~full & (occupied < (WIDTH_BUFF+1)'(BUFF_DEPTH));

	assign wr_strobe = (state == SERV_RUN) & ~cmd.is_load & ~empty;
	assign rd_strobe = (state == SERV_RUN) & cmd.is_load & rd_room;
	assign out_pop   = ((state == SERV_RUN) | (state == SERV_DRAIN)) & cmd.is_load
		& ~empty & (out_credits != '0);

	////////////////////////////// Buffer and port drive
	assign push      = store_in.valid | rd_q;
	assign push_data = rd_q ? mem_rdata : store_in.data;
	assign pop       = wr_strobe | out_pop;

	assign mem_req = '{
		req:   state == SERV_WAIT_GRANT,
		rls:   state == SERV_RELEASE,
		wr:    wr_strobe,
		rd:    rd_strobe,
		wdata: pop_data
	};

	assign cmd_done      = state == SERV_RELEASE;
	assign ext_in_credit = hdr_credit | in_credit_q;	// Never coincide
	assign ext_out       = '{valid: out_valid_q, data: out_data_q};

	////////////////////////////// Service FSM
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= SERV_IDLE;
		end else begin
			case (state)
				SERV_IDLE: begin
					if (cmd_valid) state <= SERV_WAIT_GRANT;
				end
				SERV_WAIT_GRANT: begin
					if (mem_grant) state <= SERV_RUN;
				end
				SERV_RUN: begin
					if (wr_strobe & mem_last) begin
						state <= SERV_RELEASE;
					end else if (rd_strobe & mem_last) begin
						state <= SERV_DRAIN;	// Last read issued
					end
				end
				SERV_DRAIN: begin
					if (out_pop & out_last) state <= SERV_RELEASE;
				end
				default: state <= SERV_IDLE;
			endcase
		end
	end

	// Word counters, cleared between commands
	always_ff @(posedge clock) begin
		if (reset || state == SERV_IDLE) begin
			mem_cnt <= '0;
			out_cnt <= '0;
		end else begin
			if (wr_strobe | rd_strobe) begin
				mem_cnt <= mem_cnt + 1'b1;
			end
			if (out_pop) begin
				out_cnt <= out_cnt + 1'b1;
			end
		end
	end

	// Output credits, spent per word and returned by the receiver
	always_ff @(posedge clock) begin
		if (reset) begin
			out_credits <= WIDTH_CREDIT'(EXT_OUT_CREDITS);
		end else begin
			case ({ext_out_credit, out_pop})
				2'b10:   out_credits <= out_credits + 1'b1;
				2'b01:   out_credits <= out_credits - 1'b1;
				default: out_credits <= out_credits;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_q        <= 1'b0;
			in_credit_q <= 1'b0;
			out_valid_q <= 1'b0;
		end else begin
			rd_q        <= rd_strobe;
			in_credit_q <= wr_strobe;	// Slot freed once written to memory
			out_valid_q <= out_pop;
		end
	end

	always_ff @(posedge clock) begin
		out_data_q <= pop_data;
	end

endmodule

//--- logic/ext_cmd_decoder.sv
/*
 * External command decoder
 * Collects operation, stride, length and base words, holds the command
 * for the service and forwards store data while the command runs
 */
module ext_cmd_decoder
	import mpu_ext_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  ext_word_t  ext_in,
	input  logic       cmd_done,
	output ext_cmd_t   cmd,
	output logic       cmd_valid,
	output ext_word_t  store_in,
	output logic       hdr_credit,
	output logic       busy
);

	cmd_state_e state;
	ext_cmd_t   cmd_q;
	logic       hdr_credit_q;
	logic       st_valid_q;
	data_t      st_data_q;

	assign cmd        = cmd_q;
	assign cmd_valid  = state == CMD_RUN;
	assign hdr_credit = hdr_credit_q;
	assign store_in   = '{valid: st_valid_q, data: st_data_q};

	// High from the first header word through the release cycle
	assign busy = (state != CMD_OP) | ext_in.valid;

	////////////////////////////// Header FSM
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= CMD_OP;
		end else begin
			case (state)
				CMD_OP:     if (ext_in.valid) state <= CMD_STRIDE;
				CMD_STRIDE: if (ext_in.valid) state <= CMD_LENGTH;
				CMD_LENGTH: if (ext_in.valid) state <= CMD_BASE;
				CMD_BASE:   if (ext_in.valid) state <= CMD_RUN;
				CMD_RUN:    if (cmd_done) state <= CMD_OP;
				default:    state <= CMD_OP;
			endcase
		end
	end

	// Header fields, one per accepted word
	always_ff @(posedge clock) begin
		if (ext_in.valid) begin
			case (state)
				CMD_OP:     cmd_q.is_load <= ext_in.data == data_t'(OP_LOAD);
				CMD_STRIDE: cmd_q.stride  <= addr_t'(ext_in.data);
				CMD_LENGTH: cmd_q.length  <= len_t'(ext_in.data);
				CMD_BASE:   cmd_q.base    <= addr_t'(ext_in.data);
				default:    cmd_q         <= cmd_q;
			endcase
		end
	end

	// Header slots come back one cycle after acceptance
	always_ff @(posedge clock) begin
		if (reset) begin
			hdr_credit_q <= 1'b0;
			st_valid_q   <= 1'b0;
		end else begin
			hdr_credit_q <= ext_in.valid & (state != CMD_RUN);
			st_valid_q   <= ext_in.valid & (state == CMD_RUN) & ~cmd_q.is_load;
		end
	end

	always_ff @(posedge clock) begin
		st_data_q <= ext_in.data;
	end

endmodule

//--- logic/mpu_ext_pkg.sv
/*
 * MPU external data service package
 * Shared widths, word types, command and port structs and FSM states
 */
package mpu_ext_pkg;

	////////////////////////////// Sizes
	localparam int WIDTH_DATA      = 32;
	localparam int MEM_DEPTH       = 256;
	localparam int WIDTH_ADDR      = 8;
	localparam int BUFF_DEPTH      = 16;	// Also the sender's initial input credits
	localparam int WIDTH_BUFF      = 4;
	localparam int EXT_OUT_CREDITS = 4;
	localparam int WIDTH_CREDIT    = 5;

	// Operation word values
	localparam int OP_LOAD  = 1;
	localparam int OP_STORE = 0;

	////////////////////////////// Word types
	typedef logic [WIDTH_DATA-1:0] data_t;
	typedef logic [WIDTH_ADDR-1:0] addr_t;
	typedef logic [7:0]            len_t;	// Zero encodes 256 words
	typedef logic [WIDTH_BUFF-1:0] buff_ptr_t;

	// One word on either external port
	typedef struct packed {
		logic  valid;
		data_t data;
	} ext_word_t;

	// Decoded four-word command
	typedef struct packed {
		logic  is_load;
		addr_t stride;
		len_t  length;
		addr_t base;
	} ext_cmd_t;

	// Service side of the data memory port
	typedef struct packed {
		logic  req;
		logic  rls;
		logic  wr;
		logic  rd;
		data_t wdata;
	} mem_req_t;

	////////////////////////////// FSM states
	typedef enum logic [2:0] {
		CMD_OP,
		CMD_STRIDE,
		CMD_LENGTH,
		CMD_BASE,
		CMD_RUN
	} cmd_state_e;

	typedef enum logic [2:0] {
		SERV_IDLE,
		SERV_WAIT_GRANT,
		SERV_RUN,
		SERV_DRAIN,
		SERV_RELEASE
	} serv_state_e;

endpackage

//--- logic/mpu_ext_top.sv
/*
 * MPU external data service top
 * Decoder, service engines, ring buffer and data memory
 */
module mpu_ext_top
	import mpu_ext_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  ext_word_t ext_in,
	input  logic      ext_out_credit,
	output logic      ext_in_credit,
	output ext_word_t ext_out,
	output logic      busy
);

	ext_cmd_t            cmd;
	logic                cmd_valid;
	logic                cmd_done;
	ext_word_t           store_in;
	logic                hdr_credit;
	mem_req_t            mem_req;
	logic                mem_grant;
	data_t               mem_rdata;
	logic                push;
	data_t               push_data;
	logic                pop;
	data_t               pop_data;
	logic                full;
	logic                empty;
	logic [WIDTH_BUFF:0] count;

	ext_cmd_decoder u_decoder (
		.clock      (clock),
		.reset      (reset),
		.ext_in     (ext_in),
		.cmd_done   (cmd_done),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.store_in   (store_in),
		.hdr_credit (hdr_credit),
		.busy       (busy)
	);

	data_service u_service (
		.clock          (clock),
		.reset          (reset),
		.cmd            (cmd),
		.cmd_valid      (cmd_valid),
		.store_in       (store_in),
		.hdr_credit     (hdr_credit),
		.ext_out_credit (ext_out_credit),
		.mem_grant      (mem_grant),
		.mem_rdata      (mem_rdata),
		.pop_data       (pop_data),
		.full           (full),
		.empty          (empty),
		.count          (count),
		.cmd_done       (cmd_done),
		.ext_out        (ext_out),
		.ext_in_credit  (ext_in_credit),
		.mem_req        (mem_req),
		.push           (push),
		.push_data      (push_data),
		.pop            (pop)
	);

	ring_buffer u_buffer (
		.clock     (clock),
		.reset     (reset),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.full      (full),
		.empty     (empty),
		.count     (count)
	);

	data_memory u_memory (
		.clock     (clock),
		.reset     (reset),
		.cmd       (cmd),
		.mem_req   (mem_req),
		.mem_grant (mem_grant),
		.mem_rdata (mem_rdata)
	);

endmodule

//--- logic/ring_buffer.sv
/*
 * Ring buffer
 * Circular staging store between the external ports and data memory,
 * with live occupancy and full and empty flags
 */
module ring_buffer
	import mpu_ext_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  logic                push,
	input  data_t               push_data,
	input  logic                pop,
	output data_t               pop_data,
	output logic                full,
	output logic                empty,
	output logic [WIDTH_BUFF:0] count
);

	data_t               storage [BUFF_DEPTH];
	buff_ptr_t           wr_ptr;
	buff_ptr_t           rd_ptr;
	logic [WIDTH_BUFF:0] count_q;

	assign pop_data = storage[rd_ptr];	// Head word, no read latency
	assign count    = count_q;
	assign full     = count_q == (WIDTH_BUFF+1)'(BUFF_DEPTH);
	assign empty    = count_q == '0;

	// Pointers wrap at BUFF_DEPTH by their width
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, push with pop leaves it unchanged
	always_ff @(posedge clock) begin
		if (reset) begin
			count_q <= '0;
		end else begin
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			storage[wr_ptr] <= push_data;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the MPU external data service testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module mpu_ext_tb \
	-f sources.f \
	-o mpu_ext_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/mpu_ext_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sources.f
logic/mpu_ext_pkg.sv
logic/ring_buffer.sv
logic/ext_cmd_decoder.sv
logic/data_service.sv
logic/data_memory.sv
logic/mpu_ext_top.sv
dv/mpu_ext_tb.sv
dv/mpu_ext_props.sv
